//--- Bender.yml
package:
  name: axi_rd_ctrl

sources:
  - include_dirs:
      - .
    files:
      - axi_rd_pkg.sv
      - axi_rd_fsm.sv
      - ar_burst_ctx.sv
      - r_beat_buffer.sv
      - axi_rd_ctrl.sv
  - target: test
    include_dirs:
      - .
    files:
      - sram_model_tb.sv
      - axi_rd_ctrl_tb.sv

//--- ar_burst_ctx.sv
////////////////////////////////////////
// read request context
// holds id, user, base and length, counts burst words
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "axi_rd_params.svh"

module ar_burst_ctx (
    input  wire logic                  clk,
    input  wire logic                  rst_n,

    input  wire axi_rd_pkg::axi_addr_t araddr_i,
    input  wire axi_rd_pkg::axi_len_t  arlen_i,
    input  wire axi_rd_pkg::axi_id_t   arid_i,
    input  wire axi_rd_pkg::axi_user_t aruser_i,

    input  wire logic                  ctx_load_i,   // AR accepted
    input  wire logic                  beat_adv_i,   // burst word granted
    input  wire logic                  use_base_i,

    output logic                       arlen_zero_o,
    output logic                       last_beat_o,
    output axi_rd_pkg::mem_addr_t      mem_a_o,
    output axi_rd_pkg::axi_id_t        rid_o,
    output axi_rd_pkg::axi_user_t      ruser_o
);

    import axi_rd_pkg::*;

    mem_addr_t word_addr;    // incoming byte address as a word index
    mem_addr_t base_q;
    axi_len_t  len_q;
    beat_cnt_t cnt_q;        // index of the next word to request

    assign word_addr    = araddr_i[`MEM_ADDR_W+`MEM_OFFSET_W-1:`MEM_OFFSET_W];
    assign arlen_zero_o = (arlen_i == '0);

    ////////////////////////////////////////
    // beat counter
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cnt_q <= '0;
        end
        else if (ctx_load_i)
        begin
            // word 0 is requested together with the AR handshake
            if (arlen_zero_o)
                cnt_q <= '0;
            else
                cnt_q <= beat_cnt_t'(1);
        end
        else if (beat_adv_i)
        begin
            cnt_q <= cnt_q + beat_cnt_t'(1);
        end
    end

    // request fields, echoed on every beat
    always_ff @(posedge clk)
    begin
        if (ctx_load_i)
        begin
            rid_o   <= arid_i;
            ruser_o <= aruser_i;
            base_q  <= word_addr;
            len_q   <= arlen_i;
        end
    end

    assign mem_a_o     = use_base_i ? word_addr : base_q + mem_addr_t'(cnt_q);
    assign last_beat_o = (cnt_q == beat_cnt_t'(len_q));

endmodule

`default_nettype wire

//--- axi_rd_ctrl.sv
////////////////////////////////////////
// axi4 read-only controller
// serves AR bursts from an arbitrated sram
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module axi_rd_ctrl (
    input  wire logic                  clk,
    input  wire logic                  rst_n,

    // AR channel
    input  wire axi_rd_pkg::axi_id_t   arid_i,
    input  wire axi_rd_pkg::axi_addr_t araddr_i,
    input  wire axi_rd_pkg::axi_len_t  arlen_i,
    input  wire axi_rd_pkg::axi_user_t aruser_i,
    input  wire logic                  arvalid_i,
    output logic                       arready_o,

    // R channel
    output axi_rd_pkg::axi_id_t        rid_o,
    output axi_rd_pkg::axi_data_t      rdata_o,
    output logic                       rlast_o,
    output axi_rd_pkg::axi_user_t      ruser_o,
    output logic                       rvalid_o,
    input  wire logic                  rready_i,

    // sram port
    output logic                       mem_cen_o,
    output axi_rd_pkg::mem_addr_t      mem_a_o,
    input  wire axi_rd_pkg::axi_data_t mem_q_i,

    // arbiter
    input  wire logic                  grant_i,
    output logic                       req_o
);

    logic arlen_zero;
    logic last_beat;
    logic ctx_load;
    logic beat_adv;
    logic use_base;
    logic capture;
    logic hold_sel;

    axi_rd_fsm fsm_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .arvalid_i    (arvalid_i),
        .arlen_zero_i (arlen_zero),
        .grant_i      (grant_i),
        .rready_i     (rready_i),
        .last_beat_i  (last_beat),
        .arready_o    (arready_o),
        .rvalid_o     (rvalid_o),
        .rlast_o      (rlast_o),
        .req_o        (req_o),
        .mem_cen_o    (mem_cen_o),
        .ctx_load_o   (ctx_load),
        .beat_adv_o   (beat_adv),
        .use_base_o   (use_base),
        .capture_o    (capture),
        .hold_sel_o   (hold_sel)
    );

    ar_burst_ctx ctx_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .araddr_i     (araddr_i),
        .arlen_i      (arlen_i),
        .arid_i       (arid_i),
        .aruser_i     (aruser_i),
        .ctx_load_i   (ctx_load),
        .beat_adv_i   (beat_adv),
        .use_base_i   (use_base),
        .arlen_zero_o (arlen_zero),
        .last_beat_o  (last_beat),
        .mem_a_o      (mem_a_o),
        .rid_o        (rid_o),
        .ruser_o      (ruser_o)
    );

    r_beat_buffer buf_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_q_i      (mem_q_i),
        .capture_i    (capture),
        .hold_sel_i   (hold_sel),
        .rdata_o      (rdata_o)
    );

endmodule

`default_nettype wire

//--- axi_rd_ctrl_tb.sv
////////////////////////////////////////
// axi read controller testbench
// random rready and grant, scoreboard checks
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "axi_rd_params.svh"

module axi_rd_ctrl_tb;

    import axi_rd_pkg::*;

    localparam int TOTAL_BEATS = 383;   // sum of all burst lengths below
    localparam int WATCHDOG    = TOTAL_BEATS * 20 + 200;

    logic clk;
    logic rst_n;
    axi_id_t   arid_i;
    axi_addr_t araddr_i;
    axi_len_t  arlen_i;
    axi_user_t aruser_i;
    logic arvalid_i, arready_o;
    axi_id_t   rid_o;
    axi_data_t rdata_o;
    axi_user_t ruser_o;
    logic rlast_o, rvalid_o, rready_i;
    logic mem_cen_o, grant_i, req_o;
    mem_addr_t mem_a_o;
    axi_data_t mem_q;

    integer seed = 32'h96db5fd7;
    logic rand_rready, rand_grant;
    int err_cnt, beat_cnt, b2b_cnt, beat_idx;

    // outstanding requests, oldest first
    mem_addr_t q_word[$];
    axi_id_t   q_id[$];
    axi_user_t q_user[$];
    axi_len_t  q_len[$];

    logic first_due, prev_stall, prev_last, beat_due;
    logic exp_arready;
    axi_data_t prev_data;
    axi_id_t   prev_id;
    axi_user_t prev_user;

    axi_rd_ctrl dut_i (
        .clk (clk), .rst_n (rst_n),
        .arid_i (arid_i), .araddr_i (araddr_i), .arlen_i (arlen_i),
        .aruser_i (aruser_i), .arvalid_i (arvalid_i), .arready_o (arready_o),
        .rid_o (rid_o), .rdata_o (rdata_o), .rlast_o (rlast_o),
        .ruser_o (ruser_o), .rvalid_o (rvalid_o), .rready_i (rready_i),
        .mem_cen_o (mem_cen_o), .mem_a_o (mem_a_o), .mem_q_i (mem_q),
        .grant_i (grant_i), .req_o (req_o)
    );

    sram_model_tb sram_i (
        .clk (clk), .cen_i (mem_cen_o), .grant_i (grant_i), .a_i (mem_a_o), .q_o (mem_q)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // expected fill word at a given word index
    function automatic axi_data_t fill_word(input mem_addr_t idx);
        return (64'(idx) * 64'h0101_0101_0101_0101) ^ 64'hA5A5_0000_0000_5A5A;
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
        err_cnt++;
    endtask

    task automatic report_problem(input string what);
        $display("%0t %s", $time, what);
        err_cnt++;
    endtask

    // random back-pressure and arbitration, one draw order per cycle
    always @(negedge clk)
    begin
        rready_i = rand_rready ? (($random(seed) & 3) != 0) : 1'b1;
        grant_i  = rand_grant ? (($random(seed) & 3) != 0) : 1'b1;
    end

    ////////////////////////////////////////
    // checks, sampled just before each rising edge
    ////////////////////////////////////////

    always
    begin
        @(negedge clk);
        #4;
        if (rst_n)
        begin
            assert (!(arready_o && !grant_i))
                else report_problem("arready_o high without grant_i");
            // idle, or the final beat is taken in this cycle
            exp_arready = grant_i
                          && ((q_word.size() == 0) || (rvalid_o && rready_i && rlast_o));
            assert (arready_o == exp_arready)
                else report_mismatch("arready_o", exp_arready, arready_o);
            assert (req_o == !mem_cen_o) else report_mismatch("req_o", !mem_cen_o, req_o);
            if (first_due)
                assert (rvalid_o) else report_problem("first beat not one cycle after AR");
            if (beat_due)
                assert (rvalid_o) else report_problem("burst beat gap with grant high");
            if (prev_stall)
            begin
                assert (rvalid_o) else report_problem("rvalid_o dropped while stalled");
                assert (rdata_o == prev_data) else report_mismatch("rdata_o", prev_data, rdata_o);
                assert (rid_o == prev_id) else report_mismatch("rid_o", prev_id, rid_o);
                assert (ruser_o == prev_user) else report_mismatch("ruser_o", prev_user, ruser_o);
                assert (rlast_o == prev_last) else report_mismatch("rlast_o", prev_last, rlast_o);
            end
            if (rvalid_o && rready_i)
            begin
                if (q_word.size() == 0)
                begin
                    report_problem("read beat without an outstanding request");
                end
                else
                begin
                    assert (rdata_o == fill_word(q_word[0] + mem_addr_t'(beat_idx)))
                        else report_mismatch("rdata_o",
                                             fill_word(q_word[0] + mem_addr_t'(beat_idx)), rdata_o);
                    assert (rid_o == q_id[0]) else report_mismatch("rid_o", q_id[0], rid_o);
                    assert (ruser_o == q_user[0]) else report_mismatch("ruser_o", q_user[0], ruser_o);
                    assert (rlast_o == (beat_idx == int'(q_len[0])))
                        else report_mismatch("rlast_o", beat_idx == int'(q_len[0]), rlast_o);
                    beat_cnt++;
                    beat_idx++;
                    if (beat_idx > int'(q_len[0]))
                    begin
                        void'(q_word.pop_front());
                        void'(q_id.pop_front());
                        void'(q_user.pop_front());
                        void'(q_len.pop_front());
                        beat_idx = 0;
                    end
                end
            end
            first_due = arvalid_i && arready_o;
            if (arvalid_i && arready_o)
            begin
                assert (q_word.size() == 0) else report_problem("AR accepted mid-transfer");
                if (rvalid_o && rready_i && rlast_o)
                    b2b_cnt++;
                q_word.push_back(araddr_i[`MEM_ADDR_W+`MEM_OFFSET_W-1:`MEM_OFFSET_W]);
                q_id.push_back(arid_i);
                q_user.push_back(aruser_i);
                q_len.push_back(arlen_i);
            end
            prev_stall = rvalid_o && !rready_i;
            beat_due   = rvalid_o && rready_i && !rlast_o && grant_i;
            prev_data  = rdata_o;
            prev_id    = rid_o;
            prev_user  = ruser_o;
            prev_last  = rlast_o;
        end
    end

    // called on a falling edge, returns on the falling edge after acceptance
    task automatic send_req(input axi_id_t id, input axi_addr_t addr,
                            input axi_len_t len, input axi_user_t user);
        logic hs;
        arid_i    = id;
        araddr_i  = addr;
        arlen_i   = len;
        aruser_i  = user;
        arvalid_i = 1'b1;
        hs = 1'b0;
        while (!hs)
        begin
            #4;
            hs = arvalid_i && arready_o;
            @(negedge clk);
        end
    endtask

    task automatic finish_test(input string name);
        arvalid_i = 1'b0;
        while (q_word.size() != 0)
            @(negedge clk);
        $display("test %s done, errors so far %0d", name, err_cnt);
    endtask

    initial
    begin
        repeat (WATCHDOG) @(posedge clk);
        $display("watchdog expired with requests still outstanding");
        $display("Test failed");
        $finish;
    end

    initial
    begin
        int b2b_before;
        rst_n = 1'b0;
        arid_i = '0;
        araddr_i = '0;
        arlen_i = '0;
        aruser_i = '0;
        arvalid_i = 1'b0;
        rready_i = 1'b1;
        grant_i = 1'b1;
        rand_rready = 1'b0;
        rand_grant = 1'b0;
        err_cnt = 0;
        beat_cnt = 0;
        b2b_cnt = 0;
        beat_idx = 0;
        first_due = 1'b0;
        prev_stall = 1'b0;
        beat_due = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        // outputs while reset is held
        assert (!rvalid_o) else report_mismatch("rvalid_o", 1'b0, rvalid_o);
        assert (!rlast_o) else report_mismatch("rlast_o", 1'b0, rlast_o);
        assert (!req_o) else report_mismatch("req_o", 1'b0, req_o);
        assert (mem_cen_o) else report_mismatch("mem_cen_o", 1'b1, mem_cen_o);
        rst_n = 1'b1;
        @(negedge clk);

        send_req(16'h0001, 32'h0000_0128, 8'd0, 10'h005);
        finish_test("single_read");

        send_req(16'h0002, 32'h0000_0400, 8'd15, 10'h0a1);
        send_req(16'h0003, 32'h0000_1000, 8'd255, 10'h3ff);
        finish_test("incr_bursts");

        rand_rready = 1'b1;
        send_req(16'h0004, 32'h0000_2008, 8'd31, 10'h111);
        send_req(16'h0005, 32'h0000_0040, 8'd0, 10'h222);
        finish_test("rready_stall");

        rand_rready = 1'b0;
        rand_grant = 1'b1;
        send_req(16'h0006, 32'h0000_3000, 8'd63, 10'h0f0);
        send_req(16'h0007, 32'h0000_0018, 8'd0, 10'h00f);
        finish_test("grant_stall");

        rand_grant = 1'b0;
        rand_rready = 1'b1;
        b2b_before = b2b_cnt;
        send_req(16'h00a8, 32'h0000_0800, 8'd7, 10'h155);
        send_req(16'h00b3, 32'h0000_0900, 8'd3, 10'h2aa);
        finish_test("back_to_back");
        if (b2b_cnt == b2b_before)
            report_problem("second request not accepted on the last beat");

        $display("summary: %0d beats checked, %0d errors", beat_cnt, err_cnt);
        if (err_cnt == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- axi_rd_fsm.sv
////////////////////////////////////////
// axi read controller state machine
// sequences AR accept, sram requests and R beats
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module axi_rd_fsm (
    input  wire logic clk,
    input  wire logic rst_n,

    input  wire logic arvalid_i,
    input  wire logic arlen_zero_i,   // incoming request is a single read
    input  wire logic grant_i,
    input  wire logic rready_i,
    input  wire logic last_beat_i,    // word being issued is the final one

    output logic      arready_o,
    output logic      rvalid_o,
    output logic      rlast_o,
    output logic      req_o,
    output logic      mem_cen_o,
    output logic      ctx_load_o,
    output logic      beat_adv_o,
    output logic      use_base_o,
    output logic      capture_o,
    output logic      hold_sel_o
);

    import axi_rd_pkg::*;

    rd_state_e state_q;
    rd_state_e state_d;

    logic fresh_word;    // sram output carries the beat on the bus
    logic hold_state;    // beat comes from the buffer
    logic last_state;    // beat on the bus ends the transfer
    logic burst_state;
    logic can_start;     // a new AR may be taken this cycle
    logic burst_issue;   // next burst word requested this cycle
    logic mem_req;

    ////////////////////////////////////////
    // state decode
    ////////////////////////////////////////

    assign fresh_word  = (state_q == SINGLE_R) || (state_q == BURST_R)
                         || (state_q == LAST_BURST_R);
    assign hold_state  = (state_q == WAIT_RREADY) || (state_q == WAIT_BURST_RREADY)
                         || (state_q == WAIT_LAST_RREADY);
    assign last_state  = (state_q == SINGLE_R) || (state_q == WAIT_RREADY)
                         || (state_q == LAST_BURST_R) || (state_q == WAIT_LAST_RREADY);
    assign burst_state = (state_q == BURST_R) || (state_q == WAIT_BURST_GRANT)
                         || (state_q == WAIT_BURST_RREADY);

    // idle, or the final beat leaves in this cycle
    assign can_start = (state_q == IDLE) || (last_state && rready_i);

    // a burst word goes out once the previous beat is taken
    assign burst_issue = (state_q == WAIT_BURST_GRANT)
                         || (((state_q == BURST_R) || (state_q == WAIT_BURST_RREADY))
                             && rready_i);

    ////////////////////////////////////////
    // outputs
    ////////////////////////////////////////

    assign mem_req    = can_start ? arvalid_i : burst_issue;
    assign req_o      = mem_req;
    assign mem_cen_o  = ~mem_req;          // active low

    assign arready_o  = can_start && grant_i;
    assign ctx_load_o = can_start && grant_i && arvalid_i;
    assign beat_adv_o = burst_issue && grant_i;
    assign use_base_o = ~burst_state;     // address straight from araddr

    assign rvalid_o   = fresh_word || hold_state;
    assign rlast_o    = last_state;

    // keep the sram word before the next cycle overwrites it
    assign capture_o  = fresh_word && !rready_i;
    assign hold_sel_o = hold_state;

    ////////////////////////////////////////
    // next state
    ////////////////////////////////////////

    always_comb
    begin
        state_d = state_q;

        if (can_start)
        begin
            if (arvalid_i && grant_i)
            begin
                if (arlen_zero_i)
                    state_d = SINGLE_R;
                else
                    state_d = BURST_R;
            end
            else
            begin
                state_d = IDLE;
            end
        end
        else
        begin
            case (state_q)
                SINGLE_R:
                begin
                    state_d = WAIT_RREADY;   // rready low here
                end

                BURST_R,
                WAIT_BURST_RREADY:
                begin
                    if (!rready_i)
                        state_d = WAIT_BURST_RREADY;
                    else if (!grant_i)
                        state_d = WAIT_BURST_GRANT;
                    else if (last_beat_i)
                        state_d = LAST_BURST_R;
                    else
                        state_d = BURST_R;
                end

                WAIT_BURST_GRANT:
                begin
                    if (grant_i)
                    begin
                        if (last_beat_i)
                            state_d = LAST_BURST_R;
                        else
                            state_d = BURST_R;
                    end
                end

                LAST_BURST_R:
                begin
                    state_d = WAIT_LAST_RREADY;
                end

                WAIT_RREADY,
                WAIT_LAST_RREADY:
                begin
                    state_d = state_q;       // wait for the master
                end

                default:
                begin
                    state_d = IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            state_q <= IDLE;
        else
            state_q <= state_d;
    end

endmodule

`default_nettype wire

//--- axi_rd_params.svh
////////////////////////////////////////
// axi read controller widths
// fixed bus and sram geometry shared by all blocks
////////////////////////////////////////

`ifndef AXI_RD_PARAMS_SVH
`define AXI_RD_PARAMS_SVH

// axi side
`define AXI_ADDR_W   32   // byte address
`define AXI_DATA_W   64   // read data
`define AXI_ID_W     16
`define AXI_USER_W   10
`define AXI_LEN_W    8    // beats minus one

// sram side
`define MEM_ADDR_W   13   // word address
`define MEM_OFFSET_W 3    // byte offset inside a 64-bit word

`endif

//--- axi_rd_pkg.sv
////////////////////////////////////////
// axi read controller types
// width typedefs and controller state encoding
////////////////////////////////////////

`default_nettype none

`include "axi_rd_params.svh"

package axi_rd_pkg;

    typedef logic [`AXI_ADDR_W-1:0]  axi_addr_t;
    typedef logic [`AXI_DATA_W-1:0]  axi_data_t;
    typedef logic [`AXI_ID_W-1:0]    axi_id_t;
    typedef logic [`AXI_USER_W-1:0]  axi_user_t;
    typedef logic [`AXI_LEN_W-1:0]   axi_len_t;
    typedef logic [`MEM_ADDR_W-1:0]  mem_addr_t;

    // one bit wider than the length so 256 beats fit
    typedef logic [`AXI_LEN_W:0]     beat_cnt_t;

    typedef enum logic [2:0] {
        IDLE,
        SINGLE_R,            // single word on the bus straight from sram
        WAIT_RREADY,         // single word held in the buffer
        BURST_R,
        WAIT_BURST_GRANT,    // beat taken, next word not granted yet
        WAIT_BURST_RREADY,
        LAST_BURST_R,
        WAIT_LAST_RREADY
    } rd_state_e;

endpackage

`default_nettype wire

//--- compile.f
+incdir+.
axi_rd_pkg.sv
axi_rd_fsm.sv
ar_burst_ctx.sv
r_beat_buffer.sv
axi_rd_ctrl.sv
sram_model_tb.sv
axi_rd_ctrl_tb.sv

//--- r_beat_buffer.sv
////////////////////////////////////////
// read beat buffer
// keeps the sram word while rready is low
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module r_beat_buffer (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire axi_rd_pkg::axi_data_t mem_q_i,
    input  wire logic                  capture_i,   // master stalled on a fresh word
    input  wire logic                  hold_sel_i,  // drive the held copy
    output axi_rd_pkg::axi_data_t      rdata_o
);

    import axi_rd_pkg::*;

    axi_data_t data_q;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            data_q <= '0;
        else if (capture_i)
            data_q <= mem_q_i;
    end

    // sram output is free to change once the word is held
    assign rdata_o = hold_sel_i ? data_q : mem_q_i;

endmodule

`default_nettype wire

//--- sram_model_tb.sv
////////////////////////////////////////
// single-port sram model
// one-cycle read latency, address-derived fill
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "axi_rd_params.svh"

module sram_model_tb (
    input  wire logic                  clk,
    input  wire logic                  cen_i,     // active low request
    input  wire logic                  grant_i,
    input  wire axi_rd_pkg::mem_addr_t a_i,
    output axi_rd_pkg::axi_data_t      q_o
);

    import axi_rd_pkg::*;

    localparam int DEPTH = 1 << `MEM_ADDR_W;

    axi_data_t mem [DEPTH];

    initial
    begin
        q_o = '0;
        for (int i = 0; i < DEPTH; i++)
        begin
            mem[i] = (64'(i) * 64'h0101_0101_0101_0101) ^ 64'hA5A5_0000_0000_5A5A;
        end
    end

    // access only happens while the arbiter grants the port
    always @(posedge clk)
    begin
        if (!cen_i && grant_i)
            q_o <= mem[a_i];
    end

endmodule

`default_nettype wire
